/* all.f */
+incdir+test
source/hps_pkg.sv
source/io_frame.sv
source/input_regs.sv
source/host_reply.sv
source/file_transfer.sv
source/hps_link.sv
test/tb_hps_link.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_hps_link -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
fi
exit 1

/* test/tb_host_tasks.svh */
// host-side tasks: word list setup, one strobed word, whole frames and core request pulses
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// start a fresh word list with its command word
task automatic new_frame(input logic [15:0] cmd);
	frame_words.delete();
	frame_words.push_back(cmd);
endtask

// strobe one word, reply sampled three cycles after the strobe
task automatic send_word(input logic [15:0] w, output logic [15:0] rsp);
	@(posedge clk_sys);
	io_strobe <= 1'b1;
	io_din    <= w;
	@(posedge clk_sys);
	io_strobe <= 1'b0;
	repeat (2) @(posedge clk_sys);
	rsp = io_dout;
endtask

// frame_words under one enable, replies collected in order
task automatic run_frame(input logic file_chan);
	logic [15:0] rsp;
	replies.delete();
	@(posedge clk_sys);
	io_enable <= ~file_chan;
	fp_enable <= file_chan;
	foreach (frame_words[i]) begin
		send_word(frame_words[i], rsp);
		replies.push_back(rsp);
	end
	@(posedge clk_sys);
	io_enable <= 1'b0;
	fp_enable <= 1'b0;
	// room for the frame-end pulse and the reply clear
	repeat (3) @(posedge clk_sys);
endtask

task automatic pulse_status_set(input logic [63:0] value);
	@(posedge clk_sys);
	status_in  <= value;
	status_set <= 1'b1;
	@(posedge clk_sys);
	status_set <= 1'b0;
	repeat (3) @(posedge clk_sys);
endtask

task automatic pulse_info_req(input logic [7:0] value);
	@(posedge clk_sys);
	info     <= value;
	info_req <= 1'b1;
	@(posedge clk_sys);
	info_req <= 1'b0;
	repeat (3) @(posedge clk_sys);
endtask

`endif

/* test/tb_hps_link.sv */
// clock, reset, watchdog, reference model, random tests and report for the hps_link testbench

`timescale 1ns/10ps

module tb_hps_link;
	import hps_pkg::*;

	localparam int CLK_PERIOD  = 8;
	localparam int N_FRAMES    = 24;
	localparam int N_REQ       = 4;
	localparam int MAX_PULSES  = 20;
	localparam int MAX_BYTES   = 64;
	// budget of 8 clock cycles per frame word or request pulse
	localparam int WORD_BUDGET = N_FRAMES * 13 + N_REQ * (5 + MAX_PULSES) + 17 + MAX_BYTES;

	logic                clk_sys = 1'b0;
	logic                rst_n;
	logic                io_enable;
	logic                fp_enable;
	logic                io_strobe;
	logic [WORD_W-1:0]   io_din;
	logic [WORD_W-1:0]   io_dout;
	logic [1:0]          buttons;
	logic                forced_scandoubler;
	logic                direct_video;
	joy_array_t          joystick;
	analog_array_t       joystick_analog;
	logic [STATUS_W-1:0] status;
	logic [STATUS_W-1:0] status_in;
	logic                status_set;
	logic [WORD_W-1:0]   status_menumask;
	logic                info_req;
	logic [7:0]          info;
	logic                ioctl_download;
	logic [15:0]         ioctl_index;
	logic [31:0]         ioctl_file_ext;
	logic                ioctl_wr;
	logic [ADDR_W-1:0]   ioctl_addr;
	logic [7:0]          ioctl_dout;

	// reference model state
	logic [31:0]         exp_joy [JOY_NUM];
	logic [15:0]         exp_ana [JOY_NUM];
	logic [STATUS_W-1:0] exp_status;
	logic [15:0]         exp_cfg;
	logic [STATUS_W-1:0] last_status;
	int                  exp_cnt;
	logic [ADDR_W-1:0]   start_addr;
	logic [34:0]         exp_wr [$];

	logic [15:0] frame_words [$];
	logic [15:0] replies [$];
	logic [15:0] w;
	logic [15:0] hi;
	logic [7:0]  info_val;
	int          idx;
	int          n;
	int          errors;
	int          err_mark;
	int          tests_passed;
	int          tests_failed;

	`include "tb_host_tasks.svh"

	hps_link u_dut (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
		errors++;
		$display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
	endtask

	task automatic note_error(input string msg);
		errors++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	task automatic mark_test();
		err_mark = errors;
	endtask

	task automatic report_test(input string name);
		if (errors == err_mark) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - err_mark);
		end
	endtask

	// joysticks 0 and 1 sit at 0x02 and 0x03 and the rest start at 0x10
	function automatic logic [15:0] joy_command(input int k);
		return (k < 2) ? 16'(2 + k) : 16'(16 + k - 2);
	endfunction

	task automatic check_inputs();
		for (int i = 0; i < JOY_NUM; i++) begin
			if (joystick[i] !== exp_joy[i])
				mismatch($sformatf("joystick[%0d]", i), 64'(joystick[i]), 64'(exp_joy[i]));
			if (joystick_analog[i] !== exp_ana[i])
				mismatch($sformatf("joystick_analog[%0d]", i),
					64'(joystick_analog[i]), 64'(exp_ana[i]));
		end
		if (status !== exp_status)
			mismatch("status", status, exp_status);
		if (buttons !== exp_cfg[1:0])
			mismatch("buttons", 64'(buttons), 64'(exp_cfg[1:0]));
		if (forced_scandoubler !== exp_cfg[4])
			mismatch("forced_scandoubler", 64'(forced_scandoubler), 64'(exp_cfg[4]));
		if (direct_video !== exp_cfg[10])
			mismatch("direct_video", 64'(direct_video), 64'(exp_cfg[10]));
	endtask

	// every write strobe is matched against the next expected address and byte
	always @(posedge clk_sys) begin
		logic [34:0] e;
		if (rst_n && ioctl_wr) begin
			if (!ioctl_download)
				note_error("ioctl_wr pulsed outside a download");
			if (exp_wr.size() == 0) begin
				note_error("unexpected ioctl_wr pulse");
			end else begin
				e = exp_wr.pop_front();
				if (ioctl_addr !== e[34:8])
					mismatch("ioctl_addr", 64'(ioctl_addr), 64'(e[34:8]));
				if (ioctl_dout !== e[7:0])
					mismatch("ioctl_dout", 64'(ioctl_dout), 64'(e[7:0]));
			end
		end
	end

	initial begin
		#(CLK_PERIOD * (WORD_BUDGET * 8 + 200));
		$display("timeout: the tests did not finish within the time budget");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(61));
		rst_n           <= 1'b0;
		io_enable       <= 1'b0;
		fp_enable       <= 1'b0;
		io_strobe       <= 1'b0;
		io_din          <= '0;
		status_in       <= '0;
		status_set      <= 1'b0;
		status_menumask <= '0;
		info_req        <= 1'b0;
		info            <= '0;
		foreach (exp_joy[i]) begin
			exp_joy[i] = '0;
			exp_ana[i] = '0;
		end
		exp_status = '0;
		exp_cfg    = '0;
		exp_cnt    = 0;
		repeat (5) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(posedge clk_sys);

		//////////////////////////////////////////////////////////////////////
		// joysticks and analog sticks
		//////////////////////////////////////////////////////////////////////
		mark_test();
		for (int t = 0; t < N_FRAMES; t++) begin
			idx = $urandom_range(0, JOY_NUM - 1);
			w   = 16'($urandom);
			hi  = 16'($urandom);
			new_frame(joy_command(idx));
			frame_words.push_back(w);
			frame_words.push_back(hi);
			run_frame(1'b0);
			exp_joy[idx] = {hi, w};
			check_inputs();
			// stick numbers above 5 must leave every stick alone
			idx = $urandom_range(0, 15);
			w   = 16'($urandom);
			new_frame(16'h001A);
			frame_words.push_back(16'(idx));
			frame_words.push_back(w);
			run_frame(1'b0);
			if (idx < JOY_NUM)
				exp_ana[idx] = w;
			check_inputs();
		end
		report_test("joystick and analog");

		//////////////////////////////////////////////////////////////////////
		// status and configuration
		//////////////////////////////////////////////////////////////////////
		mark_test();
		for (int t = 0; t < N_FRAMES; t++) begin
			new_frame(16'h001E);
			for (int j = 0; j < 4; j++) begin
				w = 16'($urandom);
				frame_words.push_back(w);
				exp_status[16*j +: 16] = w;
			end
			run_frame(1'b0);
			check_inputs();
			exp_cfg = 16'($urandom);
			new_frame(16'h0001);
			frame_words.push_back(exp_cfg);
			run_frame(1'b0);
			check_inputs();
		end
		report_test("status and config");

		//////////////////////////////////////////////////////////////////////
		// status requests
		//////////////////////////////////////////////////////////////////////
		mark_test();
		for (int r = 0; r < N_REQ; r++) begin
			n = $urandom_range(1, MAX_PULSES);
			for (int p = 0; p < n; p++) begin
				last_status = {$urandom, $urandom};
				pulse_status_set(last_status);
			end
			exp_cnt = exp_cnt + n;
			new_frame(16'h0029);
			repeat (4) frame_words.push_back(16'h0000);
			run_frame(1'b0);
			if (replies[0] !== 16'(32'hA0 + exp_cnt % 16))
				mismatch("io_dout", 64'(replies[0]), 64'(32'hA0 + exp_cnt % 16));
			for (int j = 0; j < 4; j++) begin
				if (replies[j+1] !== last_status[16*j +: 16])
					mismatch($sformatf("io_dout slice %0d", j),
						64'(replies[j+1]), 64'(last_status[16*j +: 16]));
			end
		end
		report_test("status request");

		//////////////////////////////////////////////////////////////////////
		// info and menu mask
		//////////////////////////////////////////////////////////////////////
		mark_test();
		info_val = 8'($urandom);
		pulse_info_req(info_val);
		new_frame(16'h0036);
		run_frame(1'b0);
		if (replies[0] !== {8'h00, info_val})
			mismatch("io_dout", 64'(replies[0]), 64'(info_val));
		// a read consumes the info byte
		new_frame(16'h0036);
		run_frame(1'b0);
		if (replies[0] !== 16'h0000)
			mismatch("io_dout", 64'(replies[0]), 64'h0);
		w = 16'($urandom);
		status_menumask <= w;
		new_frame(16'h002E);
		frame_words.push_back(16'h0000);
		run_frame(1'b0);
		if (replies[1] !== w)
			mismatch("io_dout", 64'(replies[1]), 64'(w));
		if (io_dout !== 16'h0000)
			mismatch("io_dout after frame end", 64'(io_dout), 64'h0);
		report_test("info and menu mask");

		//////////////////////////////////////////////////////////////////////
		// file download
		//////////////////////////////////////////////////////////////////////
		mark_test();
		idx = $urandom_range(0, 65535);
		new_frame(16'h0055);
		frame_words.push_back(16'(idx));
		run_frame(1'b1);
		hi = 16'($urandom);
		w  = 16'($urandom);
		new_frame(16'h0056);
		frame_words.push_back(hi);
		frame_words.push_back(w);
		run_frame(1'b1);
		start_addr = 27'($urandom);
		new_frame(16'h0053);
		frame_words.push_back(16'h0001);
		frame_words.push_back(start_addr[15:0]);
		frame_words.push_back({5'b0, start_addr[26:16]});
		run_frame(1'b1);
		if (ioctl_download !== 1'b1)
			mismatch("ioctl_download", 64'(ioctl_download), 64'h1);
		n = $urandom_range(1, MAX_BYTES);
		new_frame(16'h0054);
		for (int k = 0; k < n; k++) begin
			frame_words.push_back(16'($urandom));
			exp_wr.push_back({27'(start_addr + k), frame_words[k+1][7:0]});
		end
		run_frame(1'b1);
		if (ioctl_download !== 1'b1)
			mismatch("ioctl_download", 64'(ioctl_download), 64'h1);
		new_frame(16'h0053);
		frame_words.push_back(16'h0000);
		run_frame(1'b1);
		if (ioctl_download !== 1'b0)
			mismatch("ioctl_download", 64'(ioctl_download), 64'h0);
		if (ioctl_addr !== 27'(start_addr + n))
			mismatch("ioctl_addr", 64'(ioctl_addr), 64'(27'(start_addr + n)));
		if (ioctl_index !== 16'(idx))
			mismatch("ioctl_index", 64'(ioctl_index), 64'(16'(idx)));
		if (ioctl_file_ext !== {hi, w})
			mismatch("ioctl_file_ext", 64'(ioctl_file_ext), 64'({hi, w}));
		if (exp_wr.size() != 0)
			note_error($sformatf("%0d expected ioctl writes never arrived", exp_wr.size()));
		report_test("file download");

		$display("tests passed: %0d  failed: %0d  errors: %0d", tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* source/hps_link.sv */
// hps_link: host command bridge top, frame stage feeding the input, reply and file stages

`timescale 1ns/10ps

module hps_link (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	// host word channel
	input  logic                         io_enable,
	input  logic                         fp_enable,
	input  logic                         io_strobe,
	input  logic [hps_pkg::WORD_W-1:0]   io_din,
	output logic [hps_pkg::WORD_W-1:0]   io_dout,
	// core inputs
	output logic [1:0]                   buttons,
	output logic                         forced_scandoubler,
	output logic                         direct_video,
	output hps_pkg::joy_array_t          joystick,
	output hps_pkg::analog_array_t       joystick_analog,
	output logic [hps_pkg::STATUS_W-1:0] status,
	// core requests
	input  logic [hps_pkg::STATUS_W-1:0] status_in,
	input  logic                         status_set,
	input  logic [hps_pkg::WORD_W-1:0]   status_menumask,
	input  logic                         info_req,
	input  logic [7:0]                   info,
	// download into core memory
	output logic                         ioctl_download,
	output logic [15:0]                  ioctl_index,
	output logic [31:0]                  ioctl_file_ext,
	output logic                         ioctl_wr,
	output logic [hps_pkg::ADDR_W-1:0]   ioctl_addr,
	output logic [7:0]                   ioctl_dout
);
	import hps_pkg::*;

	io_word_t  word;
	core_cfg_t cfg;

	assign buttons            = cfg.buttons;
	assign forced_scandoubler = cfg.forced_scandoubler;
	assign direct_video       = cfg.direct_video;

	io_frame u_frame (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.io_enable(io_enable), .fp_enable(fp_enable),
		.io_strobe(io_strobe), .io_din(io_din),
		.word(word)
	);

	// three consumers read the same word in parallel
	input_regs u_input (
		.clk_sys(clk_sys), .rst_n(rst_n), .word(word),
		.cfg(cfg), .joystick(joystick),
		.joystick_analog(joystick_analog), .status(status)
	);

	host_reply u_reply (
		.clk_sys(clk_sys), .rst_n(rst_n), .word(word),
		.status_in(status_in), .status_set(status_set),
		.status_menumask(status_menumask),
		.info_req(info_req), .info(info), .io_dout(io_dout)
	);

	file_transfer u_file (
		.clk_sys(clk_sys), .rst_n(rst_n), .word(word),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index),
		.ioctl_file_ext(ioctl_file_ext), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout)
	);

endmodule

/* source/file_transfer.sv */
// file_transfer: file index, extension and download byte writes into core memory

`timescale 1ns/10ps

module file_transfer (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  hps_pkg::io_word_t          word,
	output logic                       ioctl_download,
	output logic [15:0]                ioctl_index,
	output logic [31:0]                ioctl_file_ext,
	output logic                       ioctl_wr,
	output logic [hps_pkg::ADDR_W-1:0] ioctl_addr,
	output logic [7:0]                 ioctl_dout
);
	import hps_pkg::*;

	logic              file_word;
	logic [ADDR_W-1:0] addr_q;

	// payload words of the file channel only
	assign file_word = word.valid & word.file_chan & (word.idx != '0);

	//////////////////////////////////////////////////////////////////////
	// file command sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			addr_q         <= '0;
		end else begin
			ioctl_wr <= 1'b0;

			if (file_word) begin
				case (word.cmd)
					// extension arrives high half first
					FIO_FILE_INFO: begin
						case (word.idx)
							IDX_W'(1): ioctl_file_ext[31:16] <= word.data;
							IDX_W'(2): ioctl_file_ext[15:0]  <= word.data;
							default: ;
						endcase
					end

					FIO_FILE_INDEX: begin
						if (word.idx == IDX_W'(1)) ioctl_index <= word.data;
					end

					FIO_FILE_TX: begin
						case (word.idx)
							IDX_W'(1): begin
								if (word.data != '0) begin
									ioctl_download <= 1'b1;
									addr_q         <= '0;
								end else begin
									// leave the end address for the core to read
									if (ioctl_download) ioctl_addr <= addr_q;
									ioctl_download <= 1'b0;
								end
							end
							// optional start address, low word then high bits
							IDX_W'(2): begin
								ioctl_addr[15:0] <= word.data;
								addr_q[15:0]     <= word.data;
							end
							IDX_W'(3): begin
								ioctl_addr[ADDR_W-1:16] <= word.data[ADDR_W-17:0];
								addr_q[ADDR_W-1:16]     <= word.data[ADDR_W-17:0];
							end
							default: ;
						endcase
					end

					// one byte per word, address advances after each write
					FIO_FILE_TX_DAT: begin
						if (ioctl_download) begin
							ioctl_addr <= addr_q;
							ioctl_dout <= word.data[7:0];
							ioctl_wr   <= 1'b1;
							addr_q     <= addr_q + 1'b1;
						end
					end

					default: ;
				endcase
			end
		end
	end

endmodule

/* source/host_reply.sv */
// host_reply: status-set and info request capture, and the reply word back to the host

`timescale 1ns/10ps

module host_reply (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  hps_pkg::io_word_t            word,
	input  logic [hps_pkg::STATUS_W-1:0] status_in,
	input  logic                         status_set,
	input  logic [hps_pkg::WORD_W-1:0]   status_menumask,
	input  logic                         info_req,
	input  logic [7:0]                   info,
	output logic [hps_pkg::WORD_W-1:0]   io_dout
);
	import hps_pkg::*;

	logic                set_d1;
	logic                set_d2;
	logic                info_d1;
	logic                info_d2;
	logic [STATUS_W-1:0] status_d1;
	logic [7:0]          info_val_d1;
	logic [STATUS_W-1:0] status_req;
	logic [3:0]          req_cnt;
	logic [7:0]          info_q;
	logic                info_read;
	logic [WORD_W-1:0]   reply;

	// reading info on the command word consumes it
	assign info_read = word.valid & ~word.file_chan & (word.idx == '0) & (word.cmd == CMD_INFO);

	// core-side inputs, sampled once before edge detection
	always_ff @(posedge clk_sys) begin
		status_d1   <= status_in;
		info_val_d1 <= info;
	end

	//////////////////////////////////////////////////////////////////////
	// reply selection
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		reply = '0;
		if (!word.file_chan) begin
			case (word.cmd)
				CMD_STATUS_REQ: begin
					case (word.idx)
						IDX_W'(0): reply = {8'h00, 4'hA, req_cnt};
						IDX_W'(1): reply = status_req[15:0];
						IDX_W'(2): reply = status_req[31:16];
						IDX_W'(3): reply = status_req[47:32];
						IDX_W'(4): reply = status_req[63:48];
						default: ;
					endcase
				end
				CMD_MENUMASK: if (word.idx == IDX_W'(1)) reply = status_menumask;
				CMD_INFO:     if (word.idx == IDX_W'(0)) reply = {8'h00, info_q};
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			set_d1     <= 1'b0;
			set_d2     <= 1'b0;
			info_d1    <= 1'b0;
			info_d2    <= 1'b0;
			status_req <= '0;
			req_cnt    <= '0;
			info_q     <= '0;
			io_dout    <= '0;
		end else begin
			set_d1  <= status_set;
			set_d2  <= set_d1;
			info_d1 <= info_req;
			info_d2 <= info_d1;

			// counter wraps, host compares it with its own copy
			if (set_d1 && !set_d2) begin
				status_req <= status_d1;
				req_cnt    <= req_cnt + 1'b1;
			end

			if (info_read) info_q <= '0;
			// a new request wins over a read in the same cycle
			if (info_d1 && !info_d2) info_q <= info_val_d1;

			if (word.frame_end) begin
				io_dout <= '0;
			end else if (word.valid) begin
				io_dout <= reply;
			end
		end
	end

endmodule

/* source/input_regs.sv */
// input_regs: configuration, joystick, analog stick and status registers from core words

`timescale 1ns/10ps

module input_regs (
	input  logic                         clk_sys,
	input  logic                         rst_n,
	input  hps_pkg::io_word_t            word,
	output hps_pkg::core_cfg_t           cfg,
	output hps_pkg::joy_array_t          joystick,
	output hps_pkg::analog_array_t       joystick_analog,
	output logic [hps_pkg::STATUS_W-1:0] status
);
	import hps_pkg::*;

	logic       core_word;
	logic       joy_hit;
	logic [2:0] joy_sel;
	logic [3:0] stick_idx;

	// payload words of the core channel only
	assign core_word = word.valid & ~word.file_chan & (word.idx != '0);

	//////////////////////////////////////////////////////////////////////
	// joystick command to stick number
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 3'd0;
		case (word.cmd)
			CMD_JOY0: joy_sel = 3'd0;
			CMD_JOY1: joy_sel = 3'd1;
			CMD_JOY2: joy_sel = 3'd2;
			CMD_JOY3: joy_sel = 3'd3;
			CMD_JOY4: joy_sel = 3'd4;
			CMD_JOY5: joy_sel = 3'd5;
			default:  joy_hit = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// register writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cfg             <= '0;
			joystick        <= '0;
			joystick_analog <= '0;
			status          <= '0;
			stick_idx       <= '0;
		end else if (core_word) begin
			// word 1 is the low half, anything after it the high half
			if (joy_hit) begin
				if (word.idx == IDX_W'(1)) begin
					joystick[joy_sel][15:0] <= word.data;
				end else begin
					joystick[joy_sel][31:16] <= word.data;
				end
			end

			case (word.cmd)
				CMD_CFG: begin
					cfg <= '{
						buttons:            word.data[1:0],
						forced_scandoubler: word.data[4],
						direct_video:       word.data[10]
					};
				end

				// word 1 picks the stick, word 2 carries Y/X
				CMD_ANALOG: begin
					if (word.idx == IDX_W'(1)) begin
						stick_idx <= word.data[3:0];
					end else if (word.idx == IDX_W'(2) && stick_idx < JOY_NUM) begin
						joystick_analog[stick_idx[2:0]] <= word.data;
					end
				end

				// 64-bit status, low slice first
				CMD_STATUS: begin
					case (word.idx)
						IDX_W'(1): status[15:0]  <= word.data;
						IDX_W'(2): status[31:16] <= word.data;
						IDX_W'(3): status[47:32] <= word.data;
						IDX_W'(4): status[63:48] <= word.data;
						default: ;
					endcase
				end

				default: ;
			endcase
		end
	end

endmodule

/* source/io_frame.sv */
// io_frame: registers strobed host words and tracks command and word index per frame

`timescale 1ns/10ps

module io_frame (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       io_enable,
	input  logic                       fp_enable,
	input  logic                       io_strobe,
	input  logic [hps_pkg::WORD_W-1:0] io_din,
	output hps_pkg::io_word_t          word
);
	import hps_pkg::*;

	logic              enable;
	logic              enable_q;
	logic [IDX_W-1:0]  idx_cnt;
	logic              valid_q;
	logic              end_q;
	logic              file_q;
	logic [IDX_W-1:0]  idx_q;
	logic [WORD_W-1:0] cmd_q;
	logic [WORD_W-1:0] data_q;

	// the host never raises both enables at once
	assign enable = io_enable | fp_enable;

	//////////////////////////////////////////////////////////////////////
	// frame control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			enable_q <= 1'b0;
			valid_q  <= 1'b0;
			end_q    <= 1'b0;
			idx_cnt  <= '0;
		end else begin
			enable_q <= enable;
			valid_q  <= enable & io_strobe;
			// one pulse after the enable is first seen low
			end_q    <= enable_q & ~enable;

			if (!enable) begin
				idx_cnt <= '0;
			end else if (io_strobe && !(&idx_cnt)) begin
				// index sticks at all-ones on very long frames
				idx_cnt <= idx_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// word capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (enable && io_strobe) begin
			file_q <= fp_enable;
			idx_q  <= idx_cnt;
			data_q <= io_din;
			// first word of a frame is the command, kept until the next frame
			if (idx_cnt == '0) begin
				cmd_q <= io_din;
			end
		end
	end

	assign word = '{
		valid:     valid_q,
		file_chan: file_q,
		idx:       idx_q,
		cmd:       cmd_q,
		data:      data_q,
		frame_end: end_q
	};

endmodule

/* source/hps_pkg.sv */
// host bridge package: word widths, command enums, decoded word and core config types

package hps_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	// host word, word index within a frame (saturates at all-ones)
	localparam int WORD_W   = 16;
	localparam int IDX_W    = 9;

	// joysticks and analog sticks share the count
	localparam int JOY_NUM  = 6;
	localparam int STATUS_W = 64;
	localparam int ADDR_W   = 27;

	//////////////////////////////////////////////////////////////////////
	// command codes
	//////////////////////////////////////////////////////////////////////

	// core channel, sent under io_enable
	typedef enum logic [WORD_W-1:0] {
		CMD_CFG        = 16'h0001,
		CMD_JOY0       = 16'h0002,
		CMD_JOY1       = 16'h0003,
		CMD_JOY2       = 16'h0010,
		CMD_JOY3       = 16'h0011,
		CMD_JOY4       = 16'h0012,
		CMD_JOY5       = 16'h0013,
		CMD_ANALOG     = 16'h001A,
		CMD_STATUS     = 16'h001E,
		CMD_STATUS_REQ = 16'h0029,
		CMD_MENUMASK   = 16'h002E,
		CMD_INFO       = 16'h0036
	} host_cmd_e;

	// file channel, sent under fp_enable
	typedef enum logic [WORD_W-1:0] {
		FIO_FILE_TX     = 16'h0053,
		FIO_FILE_TX_DAT = 16'h0054,
		FIO_FILE_INDEX  = 16'h0055,
		FIO_FILE_INFO   = 16'h0056
	} file_cmd_e;

	//////////////////////////////////////////////////////////////////////
	// shared types
	//////////////////////////////////////////////////////////////////////

	// one strobed host word, as seen by every consumer stage
	typedef struct packed {
		logic              valid;
		logic              file_chan;
		logic [IDX_W-1:0]  idx;
		logic [WORD_W-1:0] cmd;
		logic [WORD_W-1:0] data;
		logic              frame_end;
	} io_word_t;

	typedef logic [JOY_NUM-1:0][31:0] joy_array_t;

	// Y in [15:8], X in [7:0]
	typedef logic [JOY_NUM-1:0][15:0] analog_array_t;

	typedef struct packed {
		logic [1:0] buttons;
		logic       forced_scandoubler;
		logic       direct_video;
	} core_cfg_t;

endpackage
